/* adapter_if.sv */
/* cmd_if carries one command from decode to execute,
   xfer_if reports an issued transaction from execute to result */
`default_nettype none

interface cmd_if import adapter_pkg::*; #(
  parameter int unsigned LINE_WIDTH = adapter_pkg::LINE_WIDTH,
  parameter int unsigned ADDR_WIDTH = adapter_pkg::ADDR_WIDTH,
  parameter int unsigned ID_WIDTH   = adapter_pkg::ID_WIDTH
) ();

  logic                    cmd_valid;
  logic                    cmd_pop;
  op_e                     op;
  logic [ADDR_WIDTH-1:0]   addr;
  logic [LINE_WIDTH-1:0]   line_data;
  logic [LINE_WIDTH/8-1:0] line_strb;
  logic [1:0]              size;
  logic [ID_WIDTH-1:0]     id;

  modport producer (
    output cmd_valid, op, addr, line_data, line_strb, size, id,
    input  cmd_pop
  );

  modport consumer (
    input  cmd_valid, op, addr, line_data, line_strb, size, id,
    output cmd_pop
  );

endinterface

interface xfer_if import adapter_pkg::*; #(
  parameter int unsigned ID_WIDTH = adapter_pkg::ID_WIDTH
) ();

  logic                start;
  op_e                 op;
  logic [ID_WIDTH-1:0] id;
  logic                done;

  modport issuer (output start, op, id, input done);
  modport collector (input start, op, id, output done);

endinterface

`default_nettype wire

/* adapter_input.txt */
// columns: op addr id size data_seed strobe_mask (hex)
// op 0 single read, 1 line read, 2 single write, 3 line write
0 00001004 1 2 00000000 FFFFFFFF
1 0000203C 2 3 00000000 FFFFFFFF
2 00003008 3 3 A0000000 0000000F
3 00004010 4 3 B0000000 FFFFFFFF
1 00005000 5 3 00000000 FFFFFFFF
3 00006000 6 3 C0000000 F0F0FF0F
0 00007002 7 1 00000000 FFFFFFFF
2 00008000 8 3 D0000000 FFFFFFFF
1 00009018 9 3 00000000 FFFFFFFF
0 0000A000 A 3 00000000 FFFFFFFF

/* adapter_pkg.sv */
/* shared definitions of the cache to AXI adapter: request opcodes, default
   widths, data types and the AXI burst and response encodings */
`default_nettype none

package adapter_pkg;

  // --------------------
  // default widths
  // --------------------
  localparam int unsigned AXI_DATA_WIDTH = 64;
  localparam int unsigned LINE_WIDTH     = 256;
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned ID_WIDTH       = 4;

  // derived from the defaults
  localparam int unsigned BEATS            = LINE_WIDTH / AXI_DATA_WIDTH;
  localparam int unsigned BEAT_IDX_WIDTH   = $clog2(BEATS);
  localparam int unsigned LINE_OFFSET_BITS = $clog2(LINE_WIDTH / 8);

  // --------------------
  // request kinds
  // --------------------
  // encoded as {we, line} so the request bits map straight onto it
  typedef enum logic [1:0] {
    OP_SINGLE_READ  = 2'b00,
    OP_LINE_READ    = 2'b01,
    OP_SINGLE_WRITE = 2'b10,
    OP_LINE_WRITE   = 2'b11
  } op_e;

  // --------------------
  // data types
  // --------------------
  typedef logic [AXI_DATA_WIDTH-1:0]                   beat_t;
  typedef logic [AXI_DATA_WIDTH/8-1:0]                 strb_t;
  typedef logic [BEATS-1:0][AXI_DATA_WIDTH-1:0]        line_t;
  typedef logic [BEATS-1:0][AXI_DATA_WIDTH/8-1:0]      line_strb_t;
  typedef logic [ID_WIDTH-1:0]                         id_t;
  typedef logic [ADDR_WIDTH-1:0]                       addr_t;

  // AXI encodings
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] RESP_OKAY  = 2'b00;

endpackage

`default_nettype wire

/* axi_adapter_top.sv */
/* cache request port to AXI4 master adapter: decode, execute and result
   stages joined by the command and transfer interfaces */
`default_nettype none

module axi_adapter_top import adapter_pkg::*; #(
  parameter int unsigned AXI_DATA_WIDTH = adapter_pkg::AXI_DATA_WIDTH,
  parameter int unsigned LINE_WIDTH     = adapter_pkg::LINE_WIDTH,
  parameter int unsigned ADDR_WIDTH     = adapter_pkg::ADDR_WIDTH,
  parameter int unsigned ID_WIDTH       = adapter_pkg::ID_WIDTH
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // cache request side
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic                        line_i,
  input  logic [ADDR_WIDTH-1:0]       addr_i,
  input  logic [LINE_WIDTH-1:0]       wdata_i,
  input  logic [LINE_WIDTH/8-1:0]     be_i,
  input  logic [1:0]                  size_i,
  input  logic [ID_WIDTH-1:0]         id_i,
  output logic                        gnt_o,
  output logic                        valid_o,
  output logic [LINE_WIDTH-1:0]       rdata_o,
  output logic [ID_WIDTH-1:0]         id_o,
  output logic                        busy_o,
  // AR channel
  output logic                        ar_valid_o,
  input  logic                        ar_ready_i,
  output logic [ADDR_WIDTH-1:0]       ar_addr_o,
  output logic [7:0]                  ar_len_o,
  output logic [2:0]                  ar_size_o,
  output logic [1:0]                  ar_burst_o,
  output logic [ID_WIDTH-1:0]         ar_id_o,
  // AW channel
  output logic                        aw_valid_o,
  input  logic                        aw_ready_i,
  output logic [ADDR_WIDTH-1:0]       aw_addr_o,
  output logic [7:0]                  aw_len_o,
  output logic [2:0]                  aw_size_o,
  output logic [1:0]                  aw_burst_o,
  output logic [ID_WIDTH-1:0]         aw_id_o,
  // W channel
  output logic                        w_valid_o,
  input  logic                        w_ready_i,
  output logic [AXI_DATA_WIDTH-1:0]   w_data_o,
  output logic [AXI_DATA_WIDTH/8-1:0] w_strb_o,
  output logic                        w_last_o,
  // R and B channels
  input  logic                        r_valid_i,
  input  logic [AXI_DATA_WIDTH-1:0]   r_data_i,
  input  logic [ID_WIDTH-1:0]         r_id_i,
  input  logic                        r_last_i,
  output logic                        r_ready_o,
  input  logic                        b_valid_i,
  input  logic [ID_WIDTH-1:0]         b_id_i,
  input  logic [1:0]                  b_resp_i,
  output logic                        b_ready_o
);

  logic slot_full;
  logic exec_busy;

  cmd_if #(
    .LINE_WIDTH(LINE_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) cmd_bus ();

  xfer_if #(.ID_WIDTH(ID_WIDTH)) xfer_bus ();

  // busy while a command waits or a transfer is open
  assign busy_o = slot_full || exec_busy;

  req_decode #(
    .LINE_WIDTH(LINE_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_decode (
    .clk_i, .rst_ni, .req_i, .we_i, .line_i, .addr_i, .wdata_i, .be_i, .size_i, .id_i,
    .gnt_o,
    .cmd        (cmd_bus.producer),
    .slot_full_o(slot_full)
  );

  xfer_execute #(
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .LINE_WIDTH    (LINE_WIDTH),
    .ADDR_WIDTH    (ADDR_WIDTH),
    .ID_WIDTH      (ID_WIDTH)
  ) u_execute (
    .clk_i, .rst_ni,
    .cmd   (cmd_bus.consumer),
    .xfer  (xfer_bus.issuer),
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o, .ar_burst_o, .ar_id_o,
    .aw_valid_o, .aw_ready_i, .aw_addr_o, .aw_len_o, .aw_size_o, .aw_burst_o, .aw_id_o,
    .w_valid_o, .w_ready_i, .w_data_o, .w_strb_o, .w_last_o,
    .busy_o(exec_busy)
  );

  resp_collect #(
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .LINE_WIDTH    (LINE_WIDTH),
    .ID_WIDTH      (ID_WIDTH)
  ) u_result (
    .clk_i, .rst_ni,
    .xfer(xfer_bus.collector),
    .r_valid_i, .r_data_i, .r_id_i, .r_last_i, .r_ready_o,
    .b_valid_i, .b_id_i, .b_resp_i, .b_ready_o,
    .valid_o, .rdata_o, .id_o
  );

endmodule

`default_nettype wire

/* req_decode.sv */
/* decode stage: classifies a cache request and holds it in the one-entry
   command slot until execute pops it */
`default_nettype none

module req_decode import adapter_pkg::*; #(
  parameter int unsigned LINE_WIDTH = adapter_pkg::LINE_WIDTH,
  parameter int unsigned ADDR_WIDTH = adapter_pkg::ADDR_WIDTH,
  parameter int unsigned ID_WIDTH   = adapter_pkg::ID_WIDTH
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic                    line_i,
  input  logic [ADDR_WIDTH-1:0]   addr_i,
  input  logic [LINE_WIDTH-1:0]   wdata_i,
  input  logic [LINE_WIDTH/8-1:0] be_i,
  input  logic [1:0]              size_i,
  input  logic [ID_WIDTH-1:0]     id_i,
  output logic                    gnt_o,
  cmd_if.producer                 cmd,
  output logic                    slot_full_o
);

  // byte offset bits inside one line
  localparam int unsigned OFFSET_BITS = $clog2(LINE_WIDTH / 8);

  logic                    full_q;
  op_e                     op_q;
  op_e                     req_op;
  logic [ADDR_WIDTH-1:0]   addr_q;
  logic [ADDR_WIDTH-1:0]   req_addr;
  logic [LINE_WIDTH-1:0]   data_q;
  logic [LINE_WIDTH/8-1:0] strb_q;
  logic [1:0]              size_q;
  logic [ID_WIDTH-1:0]     id_q;

  assign req_op = op_e'({we_i, line_i});

  // line bursts start at the line boundary
  always_comb begin
    req_addr = addr_i;
    if (line_i) begin
      req_addr[OFFSET_BITS-1:0] = '0;
    end
  end

  // slot free now, or freed by a pop in this cycle
  assign gnt_o = req_i && (!full_q || cmd.cmd_pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (gnt_o) begin
      full_q <= 1'b1;
    end else if (cmd.cmd_pop) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      op_q   <= req_op;
      addr_q <= req_addr;
      data_q <= wdata_i;
      strb_q <= be_i;
      size_q <= size_i;
      id_q   <= id_i;
    end
  end

  assign cmd.cmd_valid = full_q;
  assign cmd.op        = op_q;
  assign cmd.addr      = addr_q;
  assign cmd.line_data = data_q;
  assign cmd.line_strb = strb_q;
  assign cmd.size      = size_q;
  assign cmd.id        = id_q;
  assign slot_full_o   = full_q;

endmodule

`default_nettype wire

/* resp_collect.sv */
/* result stage: accepts R beats and B responses, assembles the line and
   reports completion to the cache and to execute */
`default_nettype none

module resp_collect import adapter_pkg::*; #(
  parameter int unsigned AXI_DATA_WIDTH = adapter_pkg::AXI_DATA_WIDTH,
  parameter int unsigned LINE_WIDTH     = adapter_pkg::LINE_WIDTH,
  parameter int unsigned ID_WIDTH       = adapter_pkg::ID_WIDTH
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  xfer_if.collector                 xfer,
  input  logic                      r_valid_i,
  input  logic [AXI_DATA_WIDTH-1:0] r_data_i,
  input  logic [ID_WIDTH-1:0]       r_id_i,
  input  logic                      r_last_i,
  output logic                      r_ready_o,
  input  logic                      b_valid_i,
  input  logic [ID_WIDTH-1:0]       b_id_i,
  input  logic [1:0]                b_resp_i,
  output logic                      b_ready_o,
  output logic                      valid_o,
  output logic [LINE_WIDTH-1:0]     rdata_o,
  output logic [ID_WIDTH-1:0]       id_o
);

  localparam int unsigned NBEATS = LINE_WIDTH / AXI_DATA_WIDTH;
  localparam int unsigned IDX_W  = $clog2(NBEATS);

  logic                  rd_act_q;
  logic                  wr_act_q;
  logic                  is_line_q;
  logic                  valid_q;
  logic [IDX_W-1:0]      cnt_q;
  logic [IDX_W-1:0]      slot;
  logic [ID_WIDTH-1:0]   exp_id_q;
  logic [ID_WIDTH-1:0]   id_q;
  logic [LINE_WIDTH-1:0] line_q;
  logic                  r_hs;
  logic                  b_hs;

  // only responses that carry the issued id are taken off the bus
  assign r_ready_o = rd_act_q && (r_id_i == exp_id_q);
  assign b_ready_o = wr_act_q && (b_id_i == exp_id_q);
  assign r_hs      = r_valid_i && r_ready_o;
  assign b_hs      = b_valid_i && b_ready_o;

  // a single read always lands in slice 0
  assign slot = is_line_q ? cnt_q : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_act_q  <= 1'b0;
      wr_act_q  <= 1'b0;
      is_line_q <= 1'b0;
      valid_q   <= 1'b0;
      cnt_q     <= '0;
    end else begin
      valid_q <= 1'b0;
      if (xfer.start) begin
        rd_act_q  <= (xfer.op == OP_SINGLE_READ) || (xfer.op == OP_LINE_READ);
        wr_act_q  <= (xfer.op == OP_SINGLE_WRITE) || (xfer.op == OP_LINE_WRITE);
        is_line_q <= (xfer.op == OP_LINE_READ) || (xfer.op == OP_LINE_WRITE);
        cnt_q     <= '0;
      end else begin
        if (r_hs) begin
          cnt_q <= cnt_q + 1'b1;
          if (r_last_i) begin
            rd_act_q <= 1'b0;
            valid_q  <= 1'b1;
          end
        end
        if (b_hs) begin
          wr_act_q <= 1'b0;
          valid_q  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer.start) begin
      line_q   <= '0;
      exp_id_q <= xfer.id;
    end else if (r_hs) begin
      line_q[slot*AXI_DATA_WIDTH +: AXI_DATA_WIDTH] <= r_data_i;
      if (r_last_i) begin
        id_q <= r_id_i;
      end
    end else if (b_hs) begin
      // bit 0 flags an error response, otherwise the line is zero
      line_q <= LINE_WIDTH'(b_resp_i != RESP_OKAY);
      id_q   <= b_id_i;
    end
  end

  assign valid_o   = valid_q;
  assign xfer.done = valid_q;
  assign rdata_o   = line_q;
  assign id_o      = id_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the adapter testbench with Verilator
verilator --binary --timing -f sim.f --top-module tb_axi_adapter -o sim_axi_adapter \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_axi_adapter > sim.log 2>&1
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || exit 1
exit 0

/* sim.f */
adapter_pkg.sv
adapter_if.sv
req_decode.sv
xfer_execute.sv
resp_collect.sv
axi_adapter_top.sv
tb_axi_adapter.sv

/* tb_axi_adapter.sv */
/* testbench for the cache to AXI adapter: request driver, AXI slave model,
   compare tasks and timeout */
`default_nettype none

module tb_axi_adapter import adapter_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NREQ  = 10;
  localparam int LIMIT = NREQ * 60 + 100;

  logic clk_i, rst_ni, req_i, we_i, line_i, gnt_o, valid_o, busy_o;
  addr_t addr_i, ar_addr_o, aw_addr_o;
  line_t wdata_i, rdata_o;
  line_strb_t be_i;
  logic [1:0] size_i, ar_burst_o, aw_burst_o, b_resp_i;
  id_t id_i, id_o, ar_id_o, aw_id_o, r_id_i, b_id_i;
  logic ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, w_last_o;
  logic [7:0] ar_len_o, aw_len_o;
  logic [2:0] ar_size_o, aw_size_o;
  beat_t w_data_o, r_data_i;
  strb_t w_strb_o;
  logic r_valid_i, r_last_i, r_ready_o, b_valid_i, b_ready_o;

  logic [31:0] stim [NREQ*6];
  integer seed = 81;
  int errors = 0;
  int other_errors = 0;
  int cycles = 0;
  bit overlap_seen = 0;
  // what the slave saw, one address entry per transaction
  int ax_cnt = 0;
  int w_cnt = 0;
  int resp_cnt = 0;
  addr_t rec_addr [NREQ];
  logic [7:0] rec_len [NREQ];
  logic [2:0] rec_size [NREQ];
  logic [1:0] rec_burst [NREQ];
  id_t rec_id [NREQ];
  bit rec_rd [NREQ];
  beat_t rec_wdata [NREQ*4];
  strb_t rec_wstrb [NREQ*4];
  logic rec_wlast [NREQ*4];
  line_t resp_line [NREQ];
  id_t resp_id [NREQ];

  axi_adapter_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_beat(input beat_t got, input strb_t gs, input beat_t exp, input strb_t es);
    if (got !== exp || gs !== es) begin
      $display("mismatch at %0t: w_data/w_strb got %h/%h expected %h/%h",
               $time, got, gs, exp, es);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_op(input op_e op, input addr_t a, input logic [1:0] sz, input int t);
    bit line;
    bit rd;
    addr_t ea;
    logic [7:0] el;
    logic [2:0] es;
    line = (op == OP_LINE_READ) || (op == OP_LINE_WRITE);
    rd = (op == OP_SINGLE_READ) || (op == OP_LINE_READ);
    ea = line ? {a[31:5], 5'b0} : a;
    el = line ? 8'd3 : 8'd0;
    es = line ? 3'd3 : {1'b0, sz};
    if (rec_rd[t] != rd || rec_addr[t] !== ea || rec_len[t] !== el ||
        rec_size[t] !== es || rec_burst[t] !== BURST_INCR) begin
      $display("mismatch at %0t: %s rd/addr/len/size/burst got %0d/%h/%0d/%0d/%0d",
               $time, op.name(), rec_rd[t], rec_addr[t], rec_len[t], rec_size[t],
               rec_burst[t]);
      $display("  expected %0d/%h/%0d/%0d/%0d", rd, ea, el, es, BURST_INCR);
      errors++;
    end
  endtask

  // --------------------
  // AXI slave model
  // --------------------
  task automatic wait_random();
    int d;
    d = $random(seed) & 3;
    repeat (d) @(negedge clk_i);
  endtask

  task automatic serve_read();
    addr_t ba;
    int n;
    rec_rd[ax_cnt] = 1;
    rec_addr[ax_cnt] = ar_addr_o;
    rec_len[ax_cnt] = ar_len_o;
    rec_size[ax_cnt] = ar_size_o;
    rec_burst[ax_cnt] = ar_burst_o;
    rec_id[ax_cnt] = ar_id_o;
    n = int'(ar_len_o) + 1;
    wait_random();
    ar_ready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    ar_ready_i = 1'b0;
    for (int k = 0; k < n; k++) begin
      wait_random();
      ba = rec_addr[ax_cnt] + addr_t'(8 * k);
      r_valid_i = 1'b1;
      r_data_i = {~ba, ba};
      r_id_i = rec_id[ax_cnt];
      r_last_i = (k == n - 1);
      @(posedge clk_i);
      while (!r_ready_o) @(posedge clk_i);
      @(negedge clk_i);
      r_valid_i = 1'b0;
      r_last_i = 1'b0;
    end
    ax_cnt++;
  endtask

  task automatic serve_write();
    int n;
    rec_rd[ax_cnt] = 0;
    rec_addr[ax_cnt] = aw_addr_o;
    rec_len[ax_cnt] = aw_len_o;
    rec_size[ax_cnt] = aw_size_o;
    rec_burst[ax_cnt] = aw_burst_o;
    rec_id[ax_cnt] = aw_id_o;
    n = int'(aw_len_o) + 1;
    wait_random();
    aw_ready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    aw_ready_i = 1'b0;
    for (int k = 0; k < n; k++) begin
      wait_random();
      if (!w_valid_o) begin
        $display("W beat %0d of transaction %0d was not offered", k, ax_cnt);
        other_errors++;
      end
      rec_wdata[w_cnt] = w_data_o;
      rec_wstrb[w_cnt] = w_strb_o;
      rec_wlast[w_cnt] = w_last_o;
      w_cnt++;
      w_ready_i = 1'b1;
      @(posedge clk_i);
      @(negedge clk_i);
      w_ready_i = 1'b0;
    end
    wait_random();
    b_valid_i = 1'b1;
    b_id_i = rec_id[ax_cnt];
    b_resp_i = RESP_OKAY;
    @(posedge clk_i);
    while (!b_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    b_valid_i = 1'b0;
    ax_cnt++;
  endtask

  initial begin
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      if (ar_valid_o) begin
        serve_read();
      end else if (aw_valid_o) begin
        serve_write();
      end
    end
  end

  // responses in arrival order
  always @(posedge clk_i) begin
    if (rst_ni && valid_o && resp_cnt < NREQ) begin
      resp_line[resp_cnt] <= rdata_o;
      resp_id[resp_cnt] <= id_o;
      resp_cnt <= resp_cnt + 1;
    end
  end

  task automatic drive_request(input int i);
    op_e op;
    op = op_e'(stim[6*i][1:0]);
    req_i = 1'b1;
    we_i = op[1];
    line_i = op[0];
    addr_i = stim[6*i+1];
    id_i = id_t'(stim[6*i+2]);
    size_i = stim[6*i+3][1:0];
    for (int k = 0; k < BEATS; k++) begin
      wdata_i[k] = beat_t'(stim[6*i+4]) + beat_t'(k);
    end
    be_i = stim[6*i+5];
    @(posedge clk_i);
    while (!gnt_o) @(posedge clk_i);
    if (ar_valid_o || aw_valid_o || w_valid_o || r_ready_o || b_ready_o) begin
      overlap_seen = 1;
    end
    @(negedge clk_i);
    // the captured request keeps the adapter busy
    if (busy_o !== 1'b1) begin
      $display("mismatch at %0t: busy_o got %b expected 1", $time, busy_o);
      errors++;
    end
    // one idle cycle lets the slot drain while the bus is still working
    req_i = 1'b0;
    @(negedge clk_i);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int wi;
    op_e op;
    addr_t a;
    line_t exp;
    logic exp_last;
    wi = 0;
    {req_i, we_i, line_i, addr_i, wdata_i, be_i, size_i, id_i} = '0;
    {ar_ready_i, aw_ready_i, w_ready_i, r_valid_i, r_data_i, r_id_i, r_last_i} = '0;
    {b_valid_i, b_id_i, b_resp_i} = '0;
    $readmemh("adapter_input.txt", stim);
    rst_ni = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if ({gnt_o, valid_o, busy_o, ar_valid_o, aw_valid_o, w_valid_o, r_ready_o,
         b_ready_o} !== 8'b0) begin
      $display("outputs are not all low after reset");
      other_errors++;
    end
    for (int i = 0; i < NREQ; i++) drive_request(i);
    while (resp_cnt < NREQ) @(negedge clk_i);
    if (busy_o !== 1'b0) begin
      $display("mismatch at %0t: busy_o got %b expected 0", $time, busy_o);
      errors++;
    end
    for (int t = 0; t < NREQ; t++) begin
      op = op_e'(stim[6*t][1:0]);
      a = stim[6*t+1];
      check_op(op, a, stim[6*t+3][1:0], t);
      check_id("ar/aw id", rec_id[t], id_t'(stim[6*t+2]));
      check_id("id_o", resp_id[t], id_t'(stim[6*t+2]));
      exp = '0;
      if (op == OP_SINGLE_READ) begin
        exp[0] = {~a, a};
      end else if (op == OP_LINE_READ) begin
        for (int k = 0; k < BEATS; k++) begin
          exp[k] = {~({a[31:5], 5'b0} + addr_t'(8 * k)), {a[31:5], 5'b0} + addr_t'(8 * k)};
        end
      end else begin
        for (int k = 0; k < ((op == OP_LINE_WRITE) ? BEATS : 1); k++) begin
          check_beat(rec_wdata[wi], rec_wstrb[wi], beat_t'(stim[6*t+4]) + beat_t'(k),
                     stim[6*t+5][8*k +: 8]);
          exp_last = (op == OP_SINGLE_WRITE) || (k == BEATS - 1);
          if (rec_wlast[wi] !== exp_last) begin
            $display("mismatch at %0t: w_last got %b expected %b on beat %0d",
                     $time, rec_wlast[wi], exp_last, k);
            errors++;
          end
          wi++;
        end
      end
      check_line("rdata_o", resp_line[t], exp);
    end
    if (!overlap_seen) begin
      $display("no request was granted while another was on the bus");
      other_errors++;
    end
    $display("errors: %0d mismatches, %0d other failures", errors, other_errors);
    if (errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // ends the run if the responses never all arrive
  initial begin
    while (cycles < LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d of %0d responses", cycles, resp_cnt, NREQ);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* xfer_execute.sv */
/* execute stage: FSM that takes one command and drives it onto the
   AXI AR channel or the AW and W channels */
`default_nettype none

module xfer_execute import adapter_pkg::*; #(
  parameter int unsigned AXI_DATA_WIDTH = adapter_pkg::AXI_DATA_WIDTH,
  parameter int unsigned LINE_WIDTH     = adapter_pkg::LINE_WIDTH,
  parameter int unsigned ADDR_WIDTH     = adapter_pkg::ADDR_WIDTH,
  parameter int unsigned ID_WIDTH       = adapter_pkg::ID_WIDTH
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  cmd_if.consumer                     cmd,
  xfer_if.issuer                      xfer,
  // AR channel
  output logic                        ar_valid_o,
  input  logic                        ar_ready_i,
  output logic [ADDR_WIDTH-1:0]       ar_addr_o,
  output logic [7:0]                  ar_len_o,
  output logic [2:0]                  ar_size_o,
  output logic [1:0]                  ar_burst_o,
  output logic [ID_WIDTH-1:0]         ar_id_o,
  // AW channel
  output logic                        aw_valid_o,
  input  logic                        aw_ready_i,
  output logic [ADDR_WIDTH-1:0]       aw_addr_o,
  output logic [7:0]                  aw_len_o,
  output logic [2:0]                  aw_size_o,
  output logic [1:0]                  aw_burst_o,
  output logic [ID_WIDTH-1:0]         aw_id_o,
  // W channel
  output logic                        w_valid_o,
  input  logic                        w_ready_i,
  output logic [AXI_DATA_WIDTH-1:0]   w_data_o,
  output logic [AXI_DATA_WIDTH/8-1:0] w_strb_o,
  output logic                        w_last_o,
  output logic                        busy_o
);

  localparam int unsigned NBEATS    = LINE_WIDTH / AXI_DATA_WIDTH;
  localparam int unsigned IDX_W     = $clog2(NBEATS);
  localparam int unsigned STRB_W    = AXI_DATA_WIDTH / 8;
  localparam logic [2:0]  BEAT_SIZE = 3'($clog2(STRB_W));
  localparam logic [7:0]  LINE_LEN  = 8'(NBEATS - 1);

  typedef enum logic [1:0] {IDLE, ISSUE_AR, ISSUE_WRITE, WAIT_DONE} state_e;

  state_e                  state_q, state_d;
  op_e                     op_q;
  logic [ADDR_WIDTH-1:0]   addr_q;
  logic [LINE_WIDTH-1:0]   line_q;
  logic [LINE_WIDTH/8-1:0] strb_q;
  logic [1:0]              size_q;
  logic [ID_WIDTH-1:0]     id_q;
  logic                    aw_done_q, aw_done_d;
  logic                    w_done_q, w_done_d;
  logic [IDX_W-1:0]        beat_q, beat_d;
  logic                    is_line;
  logic                    last_beat;
  logic [7:0]              len;
  logic [2:0]              size;

  assign cmd.cmd_pop = (state_q == IDLE) && cmd.cmd_valid;
  assign busy_o      = (state_q != IDLE);

  assign is_line   = (op_q == OP_LINE_READ) || (op_q == OP_LINE_WRITE);
  assign last_beat = !is_line || (beat_q == IDX_W'(NBEATS - 1));
  assign len       = is_line ? LINE_LEN : 8'd0;
  assign size      = is_line ? BEAT_SIZE : {1'b0, size_q};

  // --------------------
  // AXI request channels
  // --------------------
  assign ar_valid_o = (state_q == ISSUE_AR);
  assign ar_addr_o  = addr_q;
  assign ar_len_o   = len;
  assign ar_size_o  = size;
  assign ar_burst_o = BURST_INCR;
  assign ar_id_o    = id_q;

  assign aw_valid_o = (state_q == ISSUE_WRITE) && !aw_done_q;
  assign aw_addr_o  = addr_q;
  assign aw_len_o   = len;
  assign aw_size_o  = size;
  assign aw_burst_o = BURST_INCR;
  assign aw_id_o    = id_q;

  // beat k is the k-th slice of the line
  assign w_valid_o = (state_q == ISSUE_WRITE) && !w_done_q;
  assign w_data_o  = line_q[beat_q*AXI_DATA_WIDTH +: AXI_DATA_WIDTH];
  assign w_strb_o  = strb_q[beat_q*STRB_W +: STRB_W];
  assign w_last_o  = last_beat;

  assign xfer.op = op_q;
  assign xfer.id = id_q;

  // --------------------
  // FSM
  // --------------------
  always_comb begin
    state_d    = state_q;
    aw_done_d  = aw_done_q;
    w_done_d   = w_done_q;
    beat_d     = beat_q;
    xfer.start = 1'b0;
    unique case (state_q)
      IDLE: begin
        aw_done_d = 1'b0;
        w_done_d  = 1'b0;
        beat_d    = '0;
        if (cmd.cmd_valid) begin
          if (cmd.op == OP_SINGLE_READ || cmd.op == OP_LINE_READ) begin
            state_d = ISSUE_AR;
          end else begin
            state_d = ISSUE_WRITE;
          end
        end
      end
      ISSUE_AR: begin
        if (ar_ready_i) begin
          xfer.start = 1'b1;
          state_d    = WAIT_DONE;
        end
      end
      ISSUE_WRITE: begin
        // AW and W complete independently
        if (aw_valid_o && aw_ready_i) begin
          aw_done_d = 1'b1;
        end
        if (w_valid_o && w_ready_i) begin
          if (last_beat) begin
            w_done_d = 1'b1;
          end else begin
            beat_d = beat_q + 1'b1;
          end
        end
        if (aw_done_d && w_done_d) begin
          xfer.start = 1'b1;
          state_d    = WAIT_DONE;
        end
      end
      WAIT_DONE: begin
        if (xfer.done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      op_q      <= OP_SINGLE_READ;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      beat_q    <= '0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
      beat_q    <= beat_d;
      if (cmd.cmd_pop) begin
        op_q <= cmd.op;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd.cmd_pop) begin
      addr_q <= cmd.addr;
      line_q <= cmd.line_data;
      strb_q <= cmd.line_strb;
      size_q <= cmd.size;
      id_q   <= cmd.id;
    end
  end

endmodule

`default_nettype wire
